// ==== src.f ====
verilog/lcd_pkg.sv
verilog/scan_timing.sv
verilog/window_decode.sv
verilog/overlay_select.sv
verilog/lcd_panel_top.sv
dv/tb_clock.sv
dv/lcd_panel_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
	--top-module lcd_panel_tb \
	-f src.f \
	-Mdir obj_dir \
	-o lcd_panel_sim

./obj_dir/lcd_panel_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "tests failed" sim.log; then
	echo "simulation reported a failure"
	exit 1
fi
if ! grep -q "all tests passed" sim.log; then
	echo "simulation ended without a result"
	exit 1
fi

// ==== dv/lcd_panel_tb.sv ====
`timescale 1ns/1ps

module lcd_panel_tb;
	import lcd_pkg::*;

	localparam logic [31:0] LCG_SEED = 32'h1bb9_fef3;
	localparam int TIMEOUT_CYCLES = 2 * H_TOTAL * V_TOTAL + 100;   // two frames plus margin

	typedef struct packed {
		int      h;
		int      v;
		logic    de;
		logic    hit;
		win_id_t id;
	} probe_t;

	localparam int N_PROBES = 23;

	// entries sorted in scan order as raw h and v then expected de, hit and id
	localparam probe_t PROBES [N_PROBES] = '{
		'{0, 0, 1'b0, 1'b0, 3'd0},                                   // both syncs low
		'{1, 1, 1'b0, 1'b0, 3'd0},                                   // last sync clocks
		'{2, 1, 1'b0, 1'b0, 3'd0},                                   // hsync up
		'{H_ACT_START - 1, V_ACT_START, 1'b0, 1'b0, 3'd0},            // just before active
		'{H_ACT_START, V_ACT_START, 1'b1, 1'b1, 3'd0},                // camera first pixel
		'{H_ACT_START + 648, V_ACT_START, 1'b1, 1'b1, 3'd2},          // title first pixel
		'{H_ACT_START + 799, V_ACT_START, 1'b1, 1'b0, 3'd0},          // last active column
		'{H_ACT_START + 800, V_ACT_START, 1'b0, 1'b0, 3'd0},          // de falls
		'{H_TOTAL - 1, V_ACT_START, 1'b0, 1'b0, 3'd0},                // h wrap
		'{H_ACT_START + 791, V_ACT_START + 15, 1'b1, 1'b1, 3'd2},     // title last pixel
		'{H_ACT_START + 730, V_ACT_START + 60, 1'b1, 1'b1, 3'd5},     // tens first pixel
		'{H_ACT_START + 650, V_ACT_START + 62, 1'b1, 1'b1, 3'd3},     // temp label
		'{H_ACT_START + 733, V_ACT_START + 65, 1'b1, 1'b1, 3'd5},     // inside tens
		'{H_ACT_START + 648, V_ACT_START + 90, 1'b1, 1'b1, 3'd4},     // heart rate label
		'{H_ACT_START + 700, V_ACT_START + 200, 1'b1, 1'b0, 3'd0},    // no window
		'{H_ACT_START + 320, V_ACT_START + 240, 1'b1, 1'b1, 3'd0},    // camera middle
		'{H_ACT_START + 672, V_ACT_START + 384, 1'b1, 1'b1, 3'd1},    // thermal first pixel
		'{H_ACT_START + 639, V_ACT_START + 479, 1'b1, 1'b1, 3'd0},    // camera last pixel
		'{H_ACT_START + 799, V_ACT_START + 479, 1'b1, 1'b1, 3'd1},    // thermal last pixel
		'{H_ACT_START + 800, V_ACT_START + 479, 1'b0, 1'b0, 3'd0},    // end of last line
		'{H_ACT_START, V_ACT_START + 480, 1'b0, 1'b0, 3'd0},          // line after active
		'{H_TOTAL - 1, V_TOTAL - 1, 1'b0, 1'b0, 3'd0},                // frame wrap
		'{0, 0, 1'b0, 1'b0, 3'd0}                                     // next frame start
	};

	logic         clk;
	logic         rst_n;
	pixel_t       data_in = '0;
	logic         lcd_clk;
	logic         lcd_pwm;
	logic         lcd_de;
	logic         lcd_blank_n;
	logic         lcd_hsync;
	logic         lcd_vsync;
	pixel_t       lcd_rgb;
	overlay_t     overlay;
	window_mask_t win_hits;

	logic [31:0] lcg_state = LCG_SEED;
	pixel_t      prev_data = '0;
	int          cycles = 0;

	// reference scan position and its two-deep history
	int   cur_h = 0;
	int   cur_v = 0;
	int   hist1_h = 0;
	int   hist1_v = 0;
	int   hist2_h = 0;
	int   hist2_v = 0;
	logic hist1_ok = 1'b0;
	logic hist2_ok = 1'b0;

	tb_clock i_tb_clock (
		.clk   (clk),
		.rst_n (rst_n)
	);

	lcd_panel_top i_lcd_panel_top (
		.clk         (clk),
		.rst_n       (rst_n),
		.data_in     (data_in),
		.lcd_clk     (lcd_clk),
		.lcd_pwm     (lcd_pwm),
		.lcd_de      (lcd_de),
		.lcd_blank_n (lcd_blank_n),
		.lcd_hsync   (lcd_hsync),
		.lcd_vsync   (lcd_vsync),
		.lcd_rgb     (lcd_rgb),
		.overlay     (overlay),
		.win_hits    (win_hits)
	);

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic bit active_at(input int h, input int v);
		return (h >= H_ACT_START) && (h < H_ACT_START + H_DISP) &&
			(v >= V_ACT_START) && (v < V_ACT_START + V_DISP);
	endfunction

	function automatic bit in_window(input win_id_t idx, input int h, input int v);
		int ax;
		int ay;
		int xs;
		int ys;
		ax = h - H_ACT_START;   // negative in blanking
		ay = v - V_ACT_START;
		xs = int'(WINDOW_TABLE[idx].x_start);
		ys = int'(WINDOW_TABLE[idx].y_start);
		return (ax >= xs) && (ax < xs + int'(WINDOW_TABLE[idx].x_size)) &&
			(ay >= ys) && (ay < ys + int'(WINDOW_TABLE[idx].y_size));
	endfunction

	function automatic window_mask_t calc_mask(input int h, input int v);
		window_mask_t mask;
		win_id_t      idx;
		mask = '0;
		for (int i = 0; i < N_WINDOWS; i++)
		begin
			idx       = win_id_t'(i);
			mask[idx] = in_window(idx, h, v);
		end
		return mask;
	endfunction

	// walks downward so the lowest hitting index is what remains
	function automatic overlay_t calc_overlay(input int h, input int v);
		overlay_t res;
		win_id_t  idx;
		res = '0;
		for (int i = N_WINDOWS - 1; i >= 0; i--)
		begin
			idx = win_id_t'(i);
			if (in_window(idx, h, v))
			begin
				res.hit     = 1'b1;
				res.id      = idx;
				res.local_x = coord_t'(h - H_ACT_START - int'(WINDOW_TABLE[idx].x_start));
				res.local_y = coord_t'(v - V_ACT_START - int'(WINDOW_TABLE[idx].y_start));
			end
		end
		return res;
	endfunction

	task automatic compare_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected)
		begin
			$display("mismatch %s: got 0x%h expected 0x%h", name, actual, expected);
			$display("tests failed");
			$fatal(1);
		end
	endtask

	task automatic check_outputs(input int h, input int v);
		logic     de;
		overlay_t exp_ov;
		de     = active_at(h, v);
		exp_ov = calc_overlay(h, v);
		compare_value("lcd_de", 32'(lcd_de), 32'(de));
		compare_value("lcd_blank_n", 32'(lcd_blank_n), 32'(de));
		compare_value("lcd_hsync", 32'(lcd_hsync), 32'(h >= H_SYNC));
		compare_value("lcd_vsync", 32'(lcd_vsync), 32'(v >= V_SYNC));
		compare_value("lcd_rgb", 32'(lcd_rgb), de ? 32'(prev_data) : 32'd0);
		compare_value("overlay", 32'(overlay), 32'(exp_ov));
		compare_value("win_hits", 32'(win_hits), 32'(calc_mask(h, v)));
	endtask

	// pipeline still empty or in reset
	task automatic check_idle();
		compare_value("lcd_de", 32'(lcd_de), 32'd0);
		compare_value("lcd_blank_n", 32'(lcd_blank_n), 32'd0);
		compare_value("lcd_hsync", 32'(lcd_hsync), 32'd0);
		compare_value("lcd_vsync", 32'(lcd_vsync), 32'd0);
		compare_value("lcd_rgb", 32'(lcd_rgb), 32'd0);
		compare_value("overlay", 32'(overlay), 32'd0);
		compare_value("win_hits", 32'(win_hits), 32'd0);
	endtask

	task automatic check_probe(input probe_t p);
		overlay_t exp_ov;
		exp_ov = calc_overlay(p.h, p.v);
		compare_value("lcd_de", 32'(lcd_de), 32'(p.de));
		compare_value("overlay.hit", 32'(overlay.hit), 32'(p.hit));
		compare_value("overlay.id", 32'(overlay.id), 32'(p.id));
		compare_value("overlay.local_x", 32'(overlay.local_x), 32'(exp_ov.local_x));
		compare_value("overlay.local_y", 32'(overlay.local_y), 32'(exp_ov.local_y));
		compare_value("win_hits", 32'(win_hits), 32'(calc_mask(p.h, p.v)));
	endtask

	task automatic wait_for_position(input int h, input int v);
		do
		begin
			@(negedge clk);
		end
		while (!(hist2_ok && (hist2_h == h) && (hist2_v == v)));
	endtask

	// pixel stimulus
	always @(posedge clk)
	begin
		lcg_state <= lcg_next(lcg_state);
		data_in   <= lcg_state[31:8];
		prev_data <= data_in;   // what the DUT registers at this edge
	end

	// reference scan counters
	always @(posedge clk)
	begin
		if (!rst_n)
		begin
			cur_h <= 0;
			cur_v <= 0;
		end
		else if (cur_h == H_TOTAL - 1)
		begin
			cur_h <= 0;
			cur_v <= (cur_v == V_TOTAL - 1) ? 0 : cur_v + 1;
		end
		else
		begin
			cur_h <= cur_h + 1;
		end
		hist1_h  <= cur_h;
		hist1_v  <= cur_v;
		hist1_ok <= rst_n;
		hist2_h  <= hist1_h;
		hist2_v  <= hist1_v;
		hist2_ok <= hist1_ok;
	end

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES)
		begin
			$display("timeout: probe table not finished after %0d cycles", cycles);
			$display("tests failed");
			$fatal(1);
		end
	end

	// all outputs checked every cycle at mid-period
	always @(negedge clk)
	begin
		if (cycles > 0)
		begin
			compare_value("lcd_pwm", 32'(lcd_pwm), 32'(rst_n));
			if (hist2_ok)
			begin
				check_outputs(hist2_h, hist2_v);
			end
			else
			begin
				check_idle();
			end
		end
	end

	// lcd_clk sampled just after each clock edge
	always @(clk)
	begin
		#1;
		compare_value("lcd_clk", 32'(lcd_clk), 32'(clk));
	end

	initial
	begin
		for (int i = 0; i < N_PROBES; i++)
		begin
			wait_for_position(PROBES[i].h, PROBES[i].v);
			check_probe(PROBES[i]);
		end
		$display("%0d probes checked after %0d cycles", N_PROBES, cycles);
		$display("all tests passed");
		$finish;
	end

endmodule

// ==== dv/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
	output logic clk,
	output logic rst_n
);
	localparam int RESET_CYCLES = 4;

	int edges = 0;

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;   // 8 ns period
	end

	// release after the fourth rising edge
	always @(posedge clk)
	begin
		if (edges < RESET_CYCLES)
		begin
			edges <= edges + 1;
		end
	end

	assign rst_n = (edges >= RESET_CYCLES);

endmodule

// ==== verilog/lcd_panel_top.sv ====
`timescale 1ns/1ps

module lcd_panel_top (
	input  logic                  clk,
	input  logic                  rst_n,
	input  lcd_pkg::pixel_t       data_in,
	output logic                  lcd_clk,
	output logic                  lcd_pwm,
	output logic                  lcd_de,
	output logic                  lcd_blank_n,
	output logic                  lcd_hsync,
	output logic                  lcd_vsync,
	output lcd_pkg::pixel_t       lcd_rgb,
	output lcd_pkg::overlay_t     overlay,
	output lcd_pkg::window_mask_t win_hits
);
	import lcd_pkg::*;

	scan_pos_t   scan_pos;
	window_hit_t hits [N_WINDOWS];

	assign lcd_clk = clk;
	assign lcd_pwm = rst_n;   // backlight on once out of reset

	scan_timing i_scan_timing (
		.clk      (clk),
		.rst_n    (rst_n),
		.scan_pos (scan_pos)
	);

	// one decoder per table entry
	for (genvar gi = 0; gi < N_WINDOWS; gi++)
	begin : g_win
		window_decode #(
			.rect (WINDOW_TABLE[gi])
		) i_window_decode (
			.clk      (clk),
			.rst_n    (rst_n),
			.scan_pos (scan_pos),
			.hit      (hits[gi])
		);
	end

	overlay_select i_overlay_select (
		.clk         (clk),
		.rst_n       (rst_n),
		.scan_pos    (scan_pos),
		.hits        (hits),
		.data_in     (data_in),
		.overlay     (overlay),
		.win_hits    (win_hits),
		.lcd_de      (lcd_de),
		.lcd_blank_n (lcd_blank_n),
		.lcd_hsync   (lcd_hsync),
		.lcd_vsync   (lcd_vsync),
		.lcd_rgb     (lcd_rgb)
	);

endmodule

// ==== verilog/overlay_select.sv ====
`timescale 1ns/1ps

module overlay_select (
	input  logic                  clk,
	input  logic                  rst_n,
	input  lcd_pkg::scan_pos_t    scan_pos,
	input  lcd_pkg::window_hit_t  hits [lcd_pkg::N_WINDOWS],
	input  lcd_pkg::pixel_t       data_in,
	output lcd_pkg::overlay_t     overlay,
	output lcd_pkg::window_mask_t win_hits,
	output logic                  lcd_de,
	output logic                  lcd_blank_n,
	output logic                  lcd_hsync,
	output logic                  lcd_vsync,
	output lcd_pkg::pixel_t       lcd_rgb
);
	import lcd_pkg::*;

	typedef struct packed {
		logic de;
		logic hsync;
		logic vsync;
	} sync_t;

	overlay_t     pick;
	window_mask_t mask;
	sync_t        sync_d1;
	sync_t        sync_d2;
	pixel_t       rgb_q;

	// lowest hitting index wins
	always_comb
	begin
		pick = '0;
		mask = '0;
		for (int i = 0; i < N_WINDOWS; i++)
		begin
			mask[i] = hits[i].hit;
			if (hits[i].hit && !pick.hit)
			begin
				pick.hit     = 1'b1;
				pick.id      = win_id_t'(i);
				pick.local_x = hits[i].local_x;
				pick.local_y = hits[i].local_y;
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			overlay  <= '0;
			win_hits <= '0;
		end
		else
		begin
			overlay  <= pick;
			win_hits <= mask;
		end
	end

	// two stages to match decode plus pick
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			sync_d1 <= '0;
			sync_d2 <= '0;
		end
		else
		begin
			sync_d1.de    <= scan_pos.de;
			sync_d1.hsync <= scan_pos.hsync;
			sync_d1.vsync <= scan_pos.vsync;
			sync_d2       <= sync_d1;
		end
	end

	always_ff @(posedge clk)
	begin
		rgb_q <= data_in;
	end

	assign lcd_de      = sync_d2.de;
	assign lcd_blank_n = sync_d2.de;
	assign lcd_hsync   = sync_d2.hsync;
	assign lcd_vsync   = sync_d2.vsync;
	assign lcd_rgb     = sync_d2.de ? rgb_q : '0;   // black in blanking

endmodule

// ==== verilog/window_decode.sv ====
`timescale 1ns/1ps

module window_decode #(
	parameter lcd_pkg::window_rect_t rect = lcd_pkg::WINDOW_TABLE[0]
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  lcd_pkg::scan_pos_t   scan_pos,
	output lcd_pkg::window_hit_t hit
);
	import lcd_pkg::*;

	coord_t act_x;
	coord_t act_y;
	coord_t off_x;
	coord_t off_y;
	logic   in_x;
	logic   in_y;
	logic   in_win;

	// position relative to the active area, wraps high in blanking
	assign act_x = scan_pos.h - coord_t'(H_ACT_START);
	assign act_y = scan_pos.v - coord_t'(V_ACT_START);

	assign off_x = act_x - rect.x_start;
	assign off_y = act_y - rect.y_start;

	assign in_x   = (act_x >= rect.x_start) && (off_x < rect.x_size);
	assign in_y   = (act_y >= rect.y_start) && (off_y < rect.y_size);
	assign in_win = in_x && in_y;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			hit <= '0;
		end
		else
		begin
			hit.hit     <= in_win;
			hit.local_x <= in_win ? off_x : '0;   // zero outside the window
			hit.local_y <= in_win ? off_y : '0;
		end
	end

endmodule

// ==== verilog/scan_timing.sv ====
`timescale 1ns/1ps

module scan_timing (
	input  logic               clk,
	input  logic               rst_n,
	output lcd_pkg::scan_pos_t scan_pos
);
	import lcd_pkg::*;

	coord_t h_cnt;
	coord_t v_cnt;
	logic   h_wrap;
	logic   v_wrap;
	logic   h_act;
	logic   v_act;

	assign h_wrap = (h_cnt == coord_t'(H_TOTAL - 1));
	assign v_wrap = (v_cnt == coord_t'(V_TOTAL - 1));

	// line counter, period of exactly H_TOTAL clocks
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			h_cnt <= '0;
		end
		else if (h_wrap)
		begin
			h_cnt <= '0;
		end
		else
		begin
			h_cnt <= h_cnt + coord_t'(1);
		end
	end

	// frame counter, steps once per line
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			v_cnt <= '0;
		end
		else if (h_wrap)
		begin
			if (v_wrap)
			begin
				v_cnt <= '0;
			end
			else
			begin
				v_cnt <= v_cnt + coord_t'(1);
			end
		end
	end

	assign h_act = (h_cnt >= coord_t'(H_ACT_START)) &&
		(h_cnt < coord_t'(H_ACT_START + H_DISP));
	assign v_act = (v_cnt >= coord_t'(V_ACT_START)) &&
		(v_cnt < coord_t'(V_ACT_START + V_DISP));

	always_comb
	begin
		scan_pos.h     = h_cnt;
		scan_pos.v     = v_cnt;
		scan_pos.de    = h_act && v_act;
		scan_pos.hsync = (h_cnt >= coord_t'(H_SYNC));   // low during sync pulse
		scan_pos.vsync = (v_cnt >= coord_t'(V_SYNC));
	end

endmodule

// ==== verilog/lcd_pkg.sv ====
package lcd_pkg;

	// 800x480 panel timing, in clocks and lines
	localparam int H_SYNC  = 2;
	localparam int H_BACK  = 44;
	localparam int H_DISP  = 800;
	localparam int H_TOTAL = 1056;

	localparam int V_SYNC  = 2;
	localparam int V_BACK  = 22;
	localparam int V_DISP  = 480;
	localparam int V_TOTAL = 524;

	localparam int H_ACT_START = H_SYNC + H_BACK;   // first active column
	localparam int V_ACT_START = V_SYNC + V_BACK;   // first active line

	localparam int N_WINDOWS = 8;
	localparam int WIN_ID_W  = 3;

	typedef logic [10:0] coord_t;
	typedef logic [23:0] pixel_t;
	typedef logic [WIN_ID_W-1:0] win_id_t;
	typedef logic [N_WINDOWS-1:0] window_mask_t;

	typedef struct packed {
		coord_t h;
		coord_t v;
		logic   de;
		logic   hsync;
		logic   vsync;
	} scan_pos_t;

	typedef struct packed {
		coord_t x_start;
		coord_t x_size;
		coord_t y_start;
		coord_t y_size;
	} window_rect_t;

	typedef struct packed {
		logic   hit;
		coord_t local_x;
		coord_t local_y;
	} window_hit_t;

	typedef struct packed {
		logic    hit;
		win_id_t id;
		coord_t  local_x;
		coord_t  local_y;
	} overlay_t;

	// x_start, x_size, y_start, y_size in active-area pixels
	// lower index wins where windows overlap
	localparam window_rect_t WINDOW_TABLE [N_WINDOWS] = '{
		'{11'd0,   11'd640, 11'd0,   11'd480},   // camera view
		'{11'd672, 11'd128, 11'd384, 11'd96},    // thermal inset
		'{11'd648, 11'd144, 11'd0,   11'd16},    // title
		'{11'd648, 11'd48,  11'd60,  11'd16},    // body temp label
		'{11'd648, 11'd48,  11'd90,  11'd16},    // heart rate label
		'{11'd730, 11'd8,   11'd60,  11'd16},    // body temp tens
		'{11'd738, 11'd8,   11'd60,  11'd16},    // body temp units
		'{11'd754, 11'd8,   11'd60,  11'd16}     // body temp decimal
	};

endpackage
